//--- logic/bus_pkg.sv
`default_nettype none

`include "cache_defines.svh"

package bus_pkg;

    // wide enough to hold the full credit count
    typedef logic [$clog2(`CACHE_REQ_CREDITS+1)-1:0] credit_cnt_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,    // issue lookup to the sram pipe
        ST_CHECK,     // hit result available
        ST_MEM_REQ,   // waiting for a memory credit
        ST_MEM_WAIT,
        ST_FILL,      // refill write into victim way
        ST_RESP
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- logic/cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_defines.svh"

module cache_ctrl (
    input  wire                       clk,
    input  wire                       rst,

    // client
    input  wire                       i_req_vld,
    input  wire cache_pkg::addr_t     i_req_addr,
    output logic                      o_req_credit,
    output logic                      o_rsp_vld,
    output cache_pkg::line_t          o_rsp_data,
    output logic                      o_rsp_hit,

    // memory
    output logic                      o_mem_req_vld,
    output cache_pkg::addr_t          o_mem_req_addr,
    input  wire                       i_mem_credit,
    input  wire                       i_mem_rsp_vld,
    input  wire cache_pkg::line_t     i_mem_rsp_data,

    // cache sram
    output logic                      o_lookup_req,
    output cache_pkg::addr_t          o_lookup_addr,
    input  wire                       i_lookup_gnt,
    input  wire                       i_lookup_hit,
    input  wire                       i_lookup_hit_rdy,
    input  wire cache_pkg::way_vec_t  i_lookup_sel_vec,
    input  wire cache_pkg::line_t     i_lookup_data,
    output logic                      o_write_req,
    output cache_pkg::addr_t          o_write_addr,
    output cache_pkg::way_vec_t       o_write_way_vec,
    output cache_pkg::line_t          o_write_data,
    input  wire                       i_init_done
);

    localparam int PTR_W = $clog2(`CACHE_REQ_CREDITS);

    bus_pkg::ctrl_state_t  state_q;

    cache_pkg::addr_t      fifo_mem [`CACHE_REQ_CREDITS];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    bus_pkg::credit_cnt_t  fifo_cnt;
    bus_pkg::credit_cnt_t  mem_credits;
    logic                  fifo_pop;
    logic                  mem_req_fire;

    cache_pkg::addr_t      cur_addr;
    cache_pkg::way_vec_t   sel_q;      // hit way or victim
    cache_pkg::line_t      fill_line;
    logic                  hit_q;

    // start a request only once the valid bits are clear
    assign fifo_pop     = (state_q == bus_pkg::ST_IDLE) && (fifo_cnt != '0) && i_init_done;
    assign mem_req_fire = (state_q == bus_pkg::ST_MEM_REQ) && (mem_credits != '0);

    // request queue
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fifo_cnt <= '0;
        end else begin
            if (i_req_vld) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (fifo_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            fifo_cnt <= fifo_cnt + bus_pkg::credit_cnt_t'(i_req_vld)
                                 - bus_pkg::credit_cnt_t'(fifo_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (i_req_vld) begin
            fifo_mem[wr_ptr] <= i_req_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_credits <= bus_pkg::credit_cnt_t'(`CACHE_MEM_CREDITS);
        end else begin
            mem_credits <= mem_credits + bus_pkg::credit_cnt_t'(i_mem_credit)
                                       - bus_pkg::credit_cnt_t'(mem_req_fire);
        end
    end

    // miss handling fsm
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= bus_pkg::ST_IDLE;
            hit_q   <= 1'b0;
        end else begin
            case (state_q)
                bus_pkg::ST_IDLE:     if (fifo_pop) state_q <= bus_pkg::ST_LOOKUP;
                bus_pkg::ST_LOOKUP:   if (i_lookup_gnt) state_q <= bus_pkg::ST_CHECK;
                bus_pkg::ST_CHECK: begin
                    if (i_lookup_hit_rdy) begin
                        hit_q   <= i_lookup_hit;
                        state_q <= i_lookup_hit ? bus_pkg::ST_RESP : bus_pkg::ST_MEM_REQ;
                    end
                end
                bus_pkg::ST_MEM_REQ:  if (mem_req_fire) state_q <= bus_pkg::ST_MEM_WAIT;
                bus_pkg::ST_MEM_WAIT: if (i_mem_rsp_vld) state_q <= bus_pkg::ST_FILL;
                bus_pkg::ST_FILL:     state_q <= bus_pkg::ST_RESP;  // write never stalls
                bus_pkg::ST_RESP:     state_q <= bus_pkg::ST_IDLE;
                default:              state_q <= bus_pkg::ST_IDLE;
            endcase
        end
    end

    // request payload
    always_ff @(posedge clk) begin
        if (fifo_pop) begin
            cur_addr <= fifo_mem[rd_ptr];
        end
        if ((state_q == bus_pkg::ST_CHECK) && i_lookup_hit_rdy) begin
            sel_q <= i_lookup_sel_vec;
        end
        if ((state_q == bus_pkg::ST_MEM_WAIT) && i_mem_rsp_vld) begin
            fill_line <= i_mem_rsp_data;
        end
    end

    assign o_req_credit    = fifo_pop;

    assign o_lookup_req    = (state_q == bus_pkg::ST_LOOKUP);
    assign o_lookup_addr   = cur_addr;
    assign o_write_req     = (state_q == bus_pkg::ST_FILL);
    assign o_write_addr    = cur_addr;
    assign o_write_way_vec = sel_q;
    assign o_write_data    = fill_line;

    assign o_mem_req_vld   = mem_req_fire;
    assign o_mem_req_addr  = cache_pkg::line_base(cur_addr);

    // hit data comes straight from stage 2 of the pipe
    assign o_rsp_vld       = (state_q == bus_pkg::ST_RESP);
    assign o_rsp_hit       = hit_q;
    assign o_rsp_data      = hit_q ? i_lookup_data : fill_line;

endmodule

`default_nettype wire

//--- logic/cache_defines.svh
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// address layout, tag | index | offset
`define CACHE_ADDR_W      16
`define CACHE_OFFSET_W    3   // byte within a 64-bit line
`define CACHE_INDEX_W     3
`define CACHE_TAG_W       (`CACHE_ADDR_W - `CACHE_INDEX_W - `CACHE_OFFSET_W)

// storage geometry
`define CACHE_LINE_W      64
`define CACHE_SETS        8
`define CACHE_WAYS        4

// flow control
`define CACHE_REQ_CREDITS 2   // same as request queue depth
`define CACHE_MEM_CREDITS 1   // one refill in flight at most

`endif

//--- logic/cache_pkg.sv
`default_nettype none

`include "cache_defines.svh"

package cache_pkg;

    typedef logic [`CACHE_ADDR_W-1:0]  addr_t;
    typedef logic [`CACHE_TAG_W-1:0]   tag_t;
    typedef logic [`CACHE_INDEX_W-1:0] index_t;
    typedef logic [`CACHE_WAYS-1:0]    way_vec_t;  // one-hot
    typedef logic [`CACHE_LINE_W-1:0]  line_t;

    // address field helpers
    function automatic tag_t addr_tag(input addr_t addr);
        return addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
    endfunction

    function automatic index_t addr_index(input addr_t addr);
        return addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
    endfunction

    function automatic addr_t line_base(input addr_t addr);
        return {addr[`CACHE_ADDR_W-1:`CACHE_OFFSET_W], {`CACHE_OFFSET_W{1'b0}}};
    endfunction

endpackage

`default_nettype wire

//--- logic/cache_sram.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_defines.svh"

// lookup: s0 read sets | s1 tag compare, select | s2 selected line out
module cache_sram (
    input  wire                       clk,
    input  wire                       rst,

    input  wire                       i_lookup_req,
    input  wire cache_pkg::addr_t     i_lookup_addr,
    output logic                      o_lookup_gnt,
    output logic                      o_lookup_hit,
    output logic                      o_lookup_hit_rdy,
    output cache_pkg::way_vec_t       o_lookup_sel_vec,  // victim when no hit
    output cache_pkg::line_t          o_lookup_data,

    input  wire                       i_write_req,
    input  wire cache_pkg::addr_t     i_write_addr,
    input  wire cache_pkg::way_vec_t  i_write_way_vec,
    input  wire cache_pkg::line_t     i_write_data,

    output logic                      o_init_done
);

    logic                 sram_read_en;
    cache_pkg::addr_t     access_addr;
    cache_pkg::way_vec_t  write_vec;

    cache_pkg::tag_t      rd_tag  [`CACHE_WAYS];
    logic                 rd_vld  [`CACHE_WAYS];
    cache_pkg::line_t     rd_data [`CACHE_WAYS];

    cache_pkg::way_vec_t  victim_vec;
    cache_pkg::way_vec_t  s1_hit_vec;
    logic                 s1_req;
    cache_pkg::tag_t      s1_tag;
    cache_pkg::line_t     s1_sel_line;
    cache_pkg::line_t     s2_line;

    // write wins the single port
    assign sram_read_en = i_lookup_req && !i_write_req;
    assign o_lookup_gnt = sram_read_en;
    assign access_addr  = i_write_req ? i_write_addr : i_lookup_addr;
    assign write_vec    = i_write_req ? i_write_way_vec : '0;

    sram_set u_sram_set (
        .clk             (clk),
        .rst             (rst),
        .i_index         (cache_pkg::addr_index(access_addr)),
        .i_read_en       (sram_read_en),
        .i_write_way_vec (write_vec),
        .i_write_tag     (cache_pkg::addr_tag(i_write_addr)),
        .i_write_data    (i_write_data),
        .o_read_tag      (rd_tag),
        .o_read_vld      (rd_vld),
        .o_read_data     (rd_data),
        .o_init_done     (o_init_done)
    );

    random_rep u_random_rep (
        .clk          (clk),
        .rst          (rst),
        .i_update     (|s1_hit_vec),  // steps on every lookup hit
        .o_victim_vec (victim_vec)
    );

    // stage 1 control
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_req <= 1'b0;
        end else begin
            s1_req <= sram_read_en;
        end
    end

    always_ff @(posedge clk) begin
        if (sram_read_en) begin
            s1_tag <= cache_pkg::addr_tag(i_lookup_addr);
        end
    end

    always_comb begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            s1_hit_vec[w] = s1_req && rd_vld[w] && (rd_tag[w] == s1_tag);
        end
    end

    assign o_lookup_hit     = |s1_hit_vec;
    assign o_lookup_hit_rdy = s1_req;
    assign o_lookup_sel_vec = (|s1_hit_vec) ? s1_hit_vec : victim_vec;

    // one-hot mux, hit way or victim
    always_comb begin
        s1_sel_line = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (o_lookup_sel_vec[w]) begin
                s1_sel_line = s1_sel_line | rd_data[w];
            end
        end
    end

    // stage 2
    always_ff @(posedge clk) begin
        if (s1_req) begin
            s2_line <= s1_sel_line;
        end
    end

    assign o_lookup_data = s2_line;

endmodule

`default_nettype wire

//--- logic/cache_top.sv
`timescale 1ns/1ps
`default_nettype none

module cache_top (
    input  wire                    clk,
    input  wire                    rst,

    input  wire                    i_req_vld,
    input  wire cache_pkg::addr_t  i_req_addr,
    output logic                   o_req_credit,
    output logic                   o_rsp_vld,
    output cache_pkg::line_t       o_rsp_data,
    output logic                   o_rsp_hit,

    output logic                   o_mem_req_vld,
    output cache_pkg::addr_t       o_mem_req_addr,
    input  wire                    i_mem_credit,
    input  wire                    i_mem_rsp_vld,
    input  wire cache_pkg::line_t  i_mem_rsp_data
);

    // controller to sram pipe
    logic                 lookup_req;
    cache_pkg::addr_t     lookup_addr;
    logic                 lookup_gnt;
    logic                 lookup_hit;
    logic                 lookup_hit_rdy;
    cache_pkg::way_vec_t  lookup_sel_vec;
    cache_pkg::line_t     lookup_data;
    logic                 write_req;
    cache_pkg::addr_t     write_addr;
    cache_pkg::way_vec_t  write_way_vec;
    cache_pkg::line_t     write_data;
    logic                 init_done;

    cache_ctrl u_cache_ctrl (
        .clk              (clk),
        .rst              (rst),
        .i_req_vld        (i_req_vld),
        .i_req_addr       (i_req_addr),
        .o_req_credit     (o_req_credit),
        .o_rsp_vld        (o_rsp_vld),
        .o_rsp_data       (o_rsp_data),
        .o_rsp_hit        (o_rsp_hit),
        .o_mem_req_vld    (o_mem_req_vld),
        .o_mem_req_addr   (o_mem_req_addr),
        .i_mem_credit     (i_mem_credit),
        .i_mem_rsp_vld    (i_mem_rsp_vld),
        .i_mem_rsp_data   (i_mem_rsp_data),
        .o_lookup_req     (lookup_req),
        .o_lookup_addr    (lookup_addr),
        .i_lookup_gnt     (lookup_gnt),
        .i_lookup_hit     (lookup_hit),
        .i_lookup_hit_rdy (lookup_hit_rdy),
        .i_lookup_sel_vec (lookup_sel_vec),
        .i_lookup_data    (lookup_data),
        .o_write_req      (write_req),
        .o_write_addr     (write_addr),
        .o_write_way_vec  (write_way_vec),
        .o_write_data     (write_data),
        .i_init_done      (init_done)
    );

    cache_sram u_cache_sram (
        .clk              (clk),
        .rst              (rst),
        .i_lookup_req     (lookup_req),
        .i_lookup_addr    (lookup_addr),
        .o_lookup_gnt     (lookup_gnt),
        .o_lookup_hit     (lookup_hit),
        .o_lookup_hit_rdy (lookup_hit_rdy),
        .o_lookup_sel_vec (lookup_sel_vec),
        .o_lookup_data    (lookup_data),
        .i_write_req      (write_req),
        .i_write_addr     (write_addr),
        .i_write_way_vec  (write_way_vec),
        .i_write_data     (write_data),
        .o_init_done      (init_done)
    );

endmodule

`default_nettype wire

//--- logic/random_rep.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_defines.svh"

module random_rep (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  i_update,
    output cache_pkg::way_vec_t  o_victim_vec
);

    localparam logic [15:0] LFSR_SEED = 16'hace1;  // any nonzero value

    logic [15:0] lfsr_q;
    logic        feedback;

    // x^16 + x^14 + x^13 + x^11, maximal length
    assign feedback = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];

    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr_q <= LFSR_SEED;
        end else if (i_update) begin
            lfsr_q <= {lfsr_q[14:0], feedback};
        end
    end

    // low bits pick the way, decode keeps it one-hot
    assign o_victim_vec = cache_pkg::way_vec_t'(1) << lfsr_q[$clog2(`CACHE_WAYS)-1:0];

endmodule

`default_nettype wire

//--- logic/sram_set.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_defines.svh"

module sram_set (
    input  wire                       clk,
    input  wire                       rst,
    input  wire cache_pkg::index_t    i_index,
    input  wire                       i_read_en,
    input  wire cache_pkg::way_vec_t  i_write_way_vec,
    input  wire cache_pkg::tag_t      i_write_tag,
    input  wire cache_pkg::line_t     i_write_data,
    output cache_pkg::tag_t           o_read_tag [`CACHE_WAYS],
    output logic                      o_read_vld [`CACHE_WAYS],
    output cache_pkg::line_t          o_read_data [`CACHE_WAYS],
    output logic                      o_init_done
);

    cache_pkg::tag_t  tag_mem  [`CACHE_WAYS][`CACHE_SETS];
    cache_pkg::line_t data_mem [`CACHE_WAYS][`CACHE_SETS];
    logic [`CACHE_WAYS-1:0] vld_mem [`CACHE_SETS];  // one bit per way, per set

    cache_pkg::index_t init_idx;

    // valid bits, cleared one set per cycle after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            init_idx    <= '0;
            o_init_done <= 1'b0;
        end else if (!o_init_done) begin
            vld_mem[init_idx] <= '0;
            init_idx          <= init_idx + 1'b1;
            if (init_idx == cache_pkg::index_t'(`CACHE_SETS-1)) begin
                o_init_done <= 1'b1;
            end
        end else begin
            vld_mem[i_index] <= vld_mem[i_index] | i_write_way_vec;  // refill marks way valid
        end
    end

    // tag and line storage, registered read
    always_ff @(posedge clk) begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (i_write_way_vec[w]) begin
                tag_mem[w][i_index]  <= i_write_tag;
                data_mem[w][i_index] <= i_write_data;
            end
            if (i_read_en) begin
                o_read_tag[w]  <= tag_mem[w][i_index];
                o_read_vld[w]  <= vld_mem[i_index][w];
                o_read_data[w] <= data_mem[w][i_index];
            end
        end
    end

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# build and run the cache testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module cache_tb \
    --Mdir obj_dir -o cache_sim || { echo "build failed"; exit 1; }

out="$(./obj_dir/cache_sim 2>&1)"
echo "$out"

echo "$out" | grep -qx "Result: PASSED" && echo "simulation passed" && exit 0 \
    || { echo "simulation failed"; exit 1; }

//--- sim.f
+incdir+logic
logic/cache_pkg.sv
logic/bus_pkg.sv
logic/sram_set.sv
logic/random_rep.sv
logic/cache_sram.sv
logic/cache_ctrl.sv
logic/cache_top.sv
tests/cache_properties.sv
tests/cache_tb.sv

//--- tests/cache_properties.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_defines.svh"

module cache_properties (
    input wire                       clk,
    input wire                       rst,
    input wire                       i_req_vld,
    input wire                       i_req_credit,
    input wire                       i_mem_req_vld,
    input wire                       i_mem_credit,
    input wire                       i_lookup_gnt,
    input wire                       i_write_req,
    input wire                       i_lookup_hit,
    input wire cache_pkg::way_vec_t  i_lookup_sel_vec
);

    int client_credits;  // credits the client holds
    int mem_credits;     // credits the cache holds

    always_ff @(posedge clk) begin
        if (rst) begin
            client_credits <= `CACHE_REQ_CREDITS;
            mem_credits    <= `CACHE_MEM_CREDITS;
        end else begin
            client_credits <= client_credits - int'(i_req_vld) + int'(i_req_credit);
            mem_credits    <= mem_credits - int'(i_mem_req_vld) + int'(i_mem_credit);
        end
    end

    // on a hit the select vector is the hit vector
    a_hit_onehot: assert property (@(posedge clk) disable iff (rst)
        i_lookup_hit |-> $onehot(i_lookup_sel_vec))
        else $error("hit vector is not one-hot");

    a_client_credit: assert property (@(posedge clk) disable iff (rst)
        (client_credits <= `CACHE_REQ_CREDITS) && (client_credits >= 0))
        else $error("client credit count out of range");

    a_mem_credit: assert property (@(posedge clk) disable iff (rst)
        i_mem_req_vld |-> (mem_credits > 0))
        else $error("memory request without a memory credit");

    a_write_priority: assert property (@(posedge clk) disable iff (rst)
        !(i_lookup_gnt && i_write_req))
        else $error("lookup granted during a write");

endmodule

bind cache_top cache_properties i_cache_properties (
    .clk              (clk),
    .rst              (rst),
    .i_req_vld        (i_req_vld),
    .i_req_credit     (o_req_credit),
    .i_mem_req_vld    (o_mem_req_vld),
    .i_mem_credit     (i_mem_credit),
    .i_lookup_gnt     (lookup_gnt),
    .i_write_req      (write_req),
    .i_lookup_hit     (lookup_hit),
    .i_lookup_sel_vec (lookup_sel_vec)
);

`default_nettype wire

//--- tests/cache_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_defines.svh"

module cache_tb;

    localparam int CLK_PERIOD = 40;
    localparam int NUM_ROWS   = 24;
    localparam int WAIT_LIMIT = 200;  // cycles allowed per wait loop

    typedef struct packed {
        logic             rst_before;  // reset the DUT before this request
        cache_pkg::addr_t addr;
        logic             exp_hit;
        logic             skip_hit;    // victim is random here
    } row_t;

    // one entry per request in flight
    typedef struct packed {
        cache_pkg::addr_t addr;
        logic             exp_hit;
        logic             skip_hit;
    } exp_t;

    logic              clk;
    logic              rst;
    logic              i_req_vld;
    cache_pkg::addr_t  i_req_addr;
    logic              o_req_credit;
    logic              o_rsp_vld;
    cache_pkg::line_t  o_rsp_data;
    logic              o_rsp_hit;
    logic              o_mem_req_vld;
    cache_pkg::addr_t  o_mem_req_addr;
    logic              i_mem_credit;
    logic              i_mem_rsp_vld;
    cache_pkg::line_t  i_mem_rsp_data;

    row_t              stim_table [NUM_ROWS];
    exp_t              exp_q [$];
    int                credits;        // client side view
    int                requests_sent;
    int                credit_pulses;
    integer            seed;

    logic              mem_pending;    // refill in flight
    logic              mem_credit_due; // credit owed for the last request
    int                mem_wait;
    cache_pkg::addr_t  mem_addr;

    cache_top i_cache_top (
        .clk            (clk),
        .rst            (rst),
        .i_req_vld      (i_req_vld),
        .i_req_addr     (i_req_addr),
        .o_req_credit   (o_req_credit),
        .o_rsp_vld      (o_rsp_vld),
        .o_rsp_data     (o_rsp_data),
        .o_rsp_hit      (o_rsp_hit),
        .o_mem_req_vld  (o_mem_req_vld),
        .o_mem_req_addr (o_mem_req_addr),
        .i_mem_credit   (i_mem_credit),
        .i_mem_rsp_vld  (i_mem_rsp_vld),
        .i_mem_rsp_data (i_mem_rsp_data)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD/2) clk = ~clk;
        end
    end

    function automatic cache_pkg::addr_t line_addr_of(input cache_pkg::addr_t addr);
        return addr & ~cache_pkg::addr_t'((1 << `CACHE_OFFSET_W) - 1);
    endfunction

    // line address in the low half and its inverse above
    function automatic cache_pkg::line_t mem_line(input cache_pkg::addr_t line_addr);
        logic [`CACHE_LINE_W/2-1:0] low;
        low = {{(`CACHE_LINE_W/2 - `CACHE_ADDR_W){1'b0}}, line_addr};
        return {~low, low};
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_line(input string name, input cache_pkg::line_t got,
                              input cache_pkg::line_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Fail %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_hit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Fail %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input cache_pkg::addr_t got,
                              input cache_pkg::addr_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Fail %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            stop_with_failure($sformatf("Fail %s got %h expected %h", name, got, exp));
        end
    endtask

    // memory model, called once per falling edge
    task automatic serve_memory();
        if (mem_credit_due) begin
            i_mem_credit   = 1'b1;  // credit back one cycle after the request
            mem_credit_due = 1'b0;
        end
        if (o_mem_req_vld === 1'b1) begin
            if (mem_pending) begin
                stop_with_failure("second memory request while a refill is outstanding");
            end
            if (exp_q.size() == 0) begin
                stop_with_failure("memory request with no client request outstanding");
            end
            if (!exp_q[0].skip_hit && exp_q[0].exp_hit) begin
                stop_with_failure("memory request for an access that should hit");
            end
            check_addr("o_mem_req_addr", o_mem_req_addr, line_addr_of(exp_q[0].addr));
            mem_addr       = o_mem_req_addr;
            mem_pending    = 1'b1;
            mem_wait       = 1 + ($unsigned($random(seed)) % 8);
            mem_credit_due = 1'b1;
        end else if (mem_pending) begin
            mem_wait--;
            if (mem_wait == 0) begin
                i_mem_rsp_vld  = 1'b1;
                i_mem_rsp_data = mem_line(mem_addr);
                mem_pending    = 1'b0;
            end
        end
    endtask

    // advance one cycle and sample outputs before driving the next inputs
    task automatic tick();
        exp_t head;
        @(negedge clk);
        if (o_req_credit === 1'b1) begin
            credits++;
            credit_pulses++;
        end
        if (o_rsp_vld === 1'b1) begin
            if (exp_q.size() == 0) begin
                stop_with_failure("response arrived with no request outstanding");
            end
            head = exp_q.pop_front();
            check_line("o_rsp_data", o_rsp_data, mem_line(line_addr_of(head.addr)));
            if (!head.skip_hit) begin
                check_hit("o_rsp_hit", o_rsp_hit, head.exp_hit);
            end
        end
        i_req_vld     = 1'b0;
        i_mem_credit  = 1'b0;
        i_mem_rsp_vld = 1'b0;
        serve_memory();
    endtask

    task automatic wait_for_credit();
        int cycles;
        cycles = 0;
        while (credits == 0) begin
            tick();
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                stop_with_failure("timeout waiting for a request credit");
            end
        end
    endtask

    task automatic wait_for_drain();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 || credits != `CACHE_REQ_CREDITS) begin
            tick();
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                stop_with_failure("timeout waiting for outstanding responses");
            end
        end
    endtask

    task automatic send_request(input row_t row);
        exp_t entry;
        i_req_vld  = 1'b1;
        i_req_addr = row.addr;
        credits--;
        requests_sent++;
        entry.addr     = row.addr;
        entry.exp_hit  = row.exp_hit;
        entry.skip_hit = row.skip_hit;
        exp_q.push_back(entry);
        tick();
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        tick();
        tick();
        rst            = 1'b0;
        credits        = `CACHE_REQ_CREDITS;
        mem_pending    = 1'b0;
        mem_credit_due = 1'b0;
    endtask

    task automatic load_table();
        // cold misses in every set
        stim_table[0]  = '{1'b0, 16'h0000, 1'b0, 1'b0};
        stim_table[1]  = '{1'b0, 16'h0048, 1'b0, 1'b0};
        stim_table[2]  = '{1'b0, 16'h0090, 1'b0, 1'b0};
        stim_table[3]  = '{1'b0, 16'h00d8, 1'b0, 1'b0};
        stim_table[4]  = '{1'b0, 16'h0120, 1'b0, 1'b0};
        stim_table[5]  = '{1'b0, 16'h0168, 1'b0, 1'b0};
        stim_table[6]  = '{1'b0, 16'h01b0, 1'b0, 1'b0};
        stim_table[7]  = '{1'b0, 16'h01f8, 1'b0, 1'b0};
        // repeats and other bytes of resident lines
        stim_table[8]  = '{1'b0, 16'h0000, 1'b1, 1'b0};
        stim_table[9]  = '{1'b0, 16'h0005, 1'b1, 1'b0};
        stim_table[10] = '{1'b0, 16'h004f, 1'b1, 1'b0};
        stim_table[11] = '{1'b0, 16'h01f8, 1'b1, 1'b0};
        // five new tags into set 2
        stim_table[12] = '{1'b0, 16'h0410, 1'b0, 1'b1};
        stim_table[13] = '{1'b0, 16'h0450, 1'b0, 1'b1};
        stim_table[14] = '{1'b0, 16'h0490, 1'b0, 1'b1};
        stim_table[15] = '{1'b0, 16'h04d0, 1'b0, 1'b1};
        stim_table[16] = '{1'b0, 16'h0510, 1'b0, 1'b1};
        stim_table[17] = '{1'b0, 16'h0410, 1'b0, 1'b1};
        stim_table[18] = '{1'b0, 16'h0090, 1'b0, 1'b1};
        stim_table[19] = '{1'b0, 16'h0094, 1'b1, 1'b0};
        // valid bits gone after the second reset
        stim_table[20] = '{1'b1, 16'h0000, 1'b0, 1'b0};
        stim_table[21] = '{1'b0, 16'h0006, 1'b1, 1'b0};
        stim_table[22] = '{1'b0, 16'h01f8, 1'b0, 1'b0};
        stim_table[23] = '{1'b0, 16'h0048, 1'b0, 1'b0};
    endtask

    initial begin
        int row;
        seed           = 32'hc0f7;
        rst            = 1'b1;
        i_req_vld      = 1'b0;
        i_req_addr     = '0;
        i_mem_credit   = 1'b0;
        i_mem_rsp_vld  = 1'b0;
        i_mem_rsp_data = '0;
        credits        = `CACHE_REQ_CREDITS;
        requests_sent  = 0;
        credit_pulses  = 0;
        mem_pending    = 1'b0;
        mem_credit_due = 1'b0;
        mem_wait       = 0;
        mem_addr       = '0;
        load_table();
        apply_reset();

        for (row = 0; row < NUM_ROWS; row++) begin
            if (stim_table[row].rst_before) begin
                wait_for_drain();
                apply_reset();
            end
            wait_for_credit();
            send_request(stim_table[row]);  // back to back while credits last
        end

        wait_for_drain();
        check_count("o_req_credit pulses", credit_pulses, requests_sent);

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire
